//--- dv/gf_arith_tb.sv
// Directed testbench for gf_arith_top at M = 8 with the default queue depth.
// Results are checked against a shift-and-reduce reference model of the field.
// All inputs change and all outputs are sampled on the falling clock edge.
`timescale 1ns/1ps
`default_nettype none

module gf_arith_tb;
	import gf_field_pkg::*;
	import gf_cmd_pkg::*;

	localparam int M = 8;
	localparam int QUEUE_DEPTH = 4;
	localparam int CLK_PERIOD = 4;
	localparam int N_BP = QUEUE_DEPTH + 3;	// More than the unit can hold
	localparam int STALL_CYCLES = 40;
	localparam int TOTAL_CMDS = 16 + 12 + 3 + N_BP + 4;
	localparam int WATCHDOG_CYCLES = TOTAL_CMDS * 200 + 8;
	localparam logic [M-1:0] POLY = M'(poly_for(M));

	logic clk;
	logic reset;
	logic in_req;
	logic in_ack;
	gf_op_t in_op;
	logic [M-1:0] in_a;
	logic [M-1:0] in_b;
	logic out_req;
	logic out_ack;
	logic [M-1:0] out_result;
	logic out_div_zero;

	int seed = 1867;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int in_ack_rises;
	int out_req_rises;
	logic prev_in_ack;
	logic prev_out_req;

	gf_arith_top #(
		.M(M),
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) UUT (
		.clk(clk),
		.reset(reset),
		.in_req(in_req),
		.in_ack(in_ack),
		.in_op(in_op),
		.in_a(in_a),
		.in_b(in_b),
		.out_req(out_req),
		.out_ack(out_ack),
		.out_result(out_result),
		.out_div_zero(out_div_zero)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Polynomial basis product by one shift and reduce per bit of b
	function automatic logic [M-1:0] ref_mul(input logic [M-1:0] a, input logic [M-1:0] b);
		logic [M-1:0] x;
		logic [M-1:0] p;
		x = a;
		p = '0;
		for (int i = 0; i < M; i++) begin
			if (b[i])
				p ^= x;
			x = x[M-1] ? ((x << 1) ^ POLY) : (x << 1);
		end
		return p;
	endfunction

	function automatic logic [M-1:0] ref_inv(input logic [M-1:0] b);
		for (int v = 1; v < (1 << M); v++)
			if (ref_mul(v[M-1:0], b) == M'(1))
				return v[M-1:0];
		return '0;
	endfunction

	function automatic logic [M-1:0] rand_elem();
		int r;
		r = $random(seed);
		return r[M-1:0];
	endfunction

	function automatic logic [M-1:0] rand_nonzero();
		logic [M-1:0] v;
		v = rand_elem();
		while (v == '0)
			v = rand_elem();
		return v;
	endfunction

	task automatic check_element(input string name, input logic [M-1:0] expected,
			input logic [M-1:0] actual);
		checks++;
		if (actual !== expected) begin
			$display("[ERROR] %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			$display("[ERROR] %s div_zero expected %b actual %b", name, expected, actual);
			errors++;
		end
	endtask

	task automatic send_cmd(input gf_op_t op, input logic [M-1:0] a, input logic [M-1:0] b);
		@(negedge clk);
		in_op = op;
		in_a = a;
		in_b = b;
		in_req = 1'b1;
		@(negedge clk);
		while (!in_ack)
			@(negedge clk);
		in_req = 1'b0;
		@(negedge clk);
		while (in_ack)
			@(negedge clk);
	endtask

	// Holds out_ack back for ack_delay cycles and watches the result stay put
	task automatic recv_result(input string name, input int ack_delay,
			output logic [M-1:0] res, output logic dz);
		@(negedge clk);
		while (!out_req)
			@(negedge clk);
		res = out_result;
		dz = out_div_zero;
		repeat (ack_delay) begin
			@(negedge clk);
			if (out_req !== 1'b1 || out_result !== res || out_div_zero !== dz) begin
				$display("%s: out_req or its result changed before out_ack", name);
				errors++;
			end
		end
		out_ack = 1'b1;
		@(negedge clk);
		while (out_req)
			@(negedge clk);
		out_ack = 1'b0;
	endtask

	task automatic run_op(input string name, input gf_op_t op, input logic [M-1:0] a,
			input logic [M-1:0] b, input int ack_delay,
			output logic [M-1:0] res, output logic dz);
		send_cmd(op, a, b);
		recv_result(name, ack_delay, res, dz);
	endtask

	task automatic report_test(input string name, input int start_errors);
		tests_run++;
		if (errors == start_errors)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - start_errors);
	endtask

	task automatic compare_product(input string name, input logic [M-1:0] a,
			input logic [M-1:0] b);
		logic [M-1:0] res;
		logic dz;
		run_op(name, OP_MUL, a, b, 0, res, dz);
		check_element(name, ref_mul(a, b), res);
		check_flag(name, 1'b0, dz);
	endtask

	task automatic multiply_sweep();
		int start;
		start = errors;
		compare_product("mul zero", '0, rand_nonzero());
		compare_product("mul one left", M'(1), rand_elem());
		compare_product("mul one right", rand_elem(), M'(1));
		compare_product("mul all ones", '1, '1);
		for (int i = 0; i < 12; i++)
			compare_product($sformatf("mul random %0d", i), rand_elem(), rand_elem());
		report_test("multiply_sweep", start);
	endtask

	task automatic divide_sweep();
		int start;
		logic [M-1:0] a;
		logic [M-1:0] b;
		logic [M-1:0] res;
		logic dz;
		start = errors;
		for (int i = 0; i < 12; i++) begin
			a = rand_elem();
			b = rand_nonzero();
			run_op("div", OP_DIV, a, b, 0, res, dz);
			check_element($sformatf("div %0d quotient times b", i), a, ref_mul(res, b));
			check_flag($sformatf("div %0d", i), 1'b0, dz);
		end
		report_test("divide_sweep", start);
	endtask

	task automatic zero_denominator();
		int start;
		logic [M-1:0] nums [3];
		logic [M-1:0] res;
		logic dz;
		start = errors;
		nums[0] = rand_nonzero();
		nums[1] = '0;
		nums[2] = '1;
		for (int i = 0; i < 3; i++) begin
			run_op("div zero", OP_DIV, nums[i], '0, 0, res, dz);
			check_element($sformatf("div zero %0d", i), '0, res);
			check_flag($sformatf("div zero %0d", i), 1'b1, dz);
		end
		report_test("zero_denominator", start);
	endtask

	task automatic backpressure_fill();
		gf_op_t ops [N_BP];
		logic [M-1:0] a_v [N_BP];
		logic [M-1:0] b_v [N_BP];
		logic [M-1:0] exp_v [N_BP];
		logic [M-1:0] res;
		logic dz;
		logic stalled;
		int accepted;
		int waited;
		int start;
		start = errors;
		for (int i = 0; i < N_BP; i++) begin
			ops[i] = i[0] ? OP_DIV : OP_MUL;
			a_v[i] = rand_elem();
			b_v[i] = rand_nonzero();
			exp_v[i] = i[0] ? ref_mul(a_v[i], ref_inv(b_v[i])) : ref_mul(a_v[i], b_v[i]);
		end
		// With out_ack low the queue fills and in_ack has to stop
		accepted = 0;
		stalled = 1'b0;
		while (accepted < N_BP && !stalled) begin
			@(negedge clk);
			in_op = ops[accepted];
			in_a = a_v[accepted];
			in_b = b_v[accepted];
			in_req = 1'b1;
			waited = 0;
			@(negedge clk);
			while (!in_ack && waited < STALL_CYCLES) begin
				@(negedge clk);
				waited++;
			end
			if (in_ack) begin
				in_req = 1'b0;
				@(negedge clk);
				while (in_ack)
					@(negedge clk);
				accepted++;
			end else begin
				stalled = 1'b1;
			end
		end
		if (!stalled) begin
			$display("in_ack kept coming back for all %0d commands with out_ack held low", N_BP);
			errors++;
		end
		// One command sits in the engine and QUEUE_DEPTH in the queue
		checks++;
		if (accepted != QUEUE_DEPTH + 1) begin
			$display("[ERROR] backpressure accepted commands expected %0d actual %0d",
				QUEUE_DEPTH + 1, accepted);
			errors++;
		end
		fork
			begin
				if (stalled) begin
					while (!in_ack)
						@(negedge clk);
					in_req = 1'b0;
					@(negedge clk);
					while (in_ack)
						@(negedge clk);
				end
				for (int j = accepted + 1; j < N_BP; j++)
					send_cmd(ops[j], a_v[j], b_v[j]);
			end
			begin
				for (int k = 0; k < N_BP; k++) begin
					recv_result("backpressure", 0, res, dz);
					check_element($sformatf("backpressure %0d", k), exp_v[k], res);
					check_flag($sformatf("backpressure %0d", k), 1'b0, dz);
				end
			end
		join
		report_test("backpressure_fill", start);
	endtask

	task automatic protocol_timing();
		int start;
		logic [M-1:0] a;
		logic [M-1:0] b;
		logic [M-1:0] res;
		logic dz;
		start = errors;
		for (int i = 0; i < 4; i++) begin
			a = rand_elem();
			b = rand_nonzero();
			run_op("protocol", i[0] ? OP_DIV : OP_MUL, a, b, 6, res, dz);
			if (i[0])
				check_element($sformatf("protocol %0d quotient times b", i), a, ref_mul(res, b));
			else
				check_element($sformatf("protocol %0d", i), ref_mul(a, b), res);
			check_flag($sformatf("protocol %0d", i), 1'b0, dz);
		end
		report_test("protocol_timing", start);
	endtask

	// Each out_req rise must belong to a command whose in_ack was already seen
	always @(negedge clk) begin
		if (reset) begin
			in_ack_rises = 0;
			out_req_rises = 0;
			prev_in_ack = 1'b0;
			prev_out_req = 1'b0;
		end else begin
			if (in_ack && !prev_in_ack)
				in_ack_rises++;
			if (out_req && !prev_out_req) begin
				out_req_rises++;
				if (out_req_rises > in_ack_rises) begin
					$display("out_req rose for a command whose in_ack was not yet seen");
					errors++;
				end
			end
			prev_in_ack = in_ack;
			prev_out_req = out_req;
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		in_req = 1'b0;
		in_op = OP_MUL;
		in_a = '0;
		in_b = '0;
		out_ack = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		multiply_sweep();
		divide_sweep();
		zero_denominator();
		backpressure_fill();
		protocol_timing();
		$display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module gf_arith_tb -f verilog.f \
	&& ./obj_dir/Vgf_arith_tb | tee /dev/stderr | grep -x "PASS: all tests" > /dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

//--- verilog.f
verilog/gf_field_pkg.sv
verilog/gf_cmd_pkg.sv
verilog/gf_cmd_if.sv
verilog/gf_op_intake.sv
verilog/gf_cmd_queue.sv
verilog/gf_mixed_multiplier.sv
verilog/gf_arith_engine.sv
verilog/gf_arith_top.sv
dv/gf_arith_tb.sv

//--- verilog/gf_arith_engine.sv
// Multiply in one cycle; divide by Fermat inversion in M-1 cycles plus one for the numerator.
// Divide by zero returns zero with out_div_zero set. The result holds while out_req is high,
// and the next command is taken only after out_ack has gone high and low again.
`timescale 1ns/1ps
`default_nettype none

module gf_arith_engine #(
	parameter int M = 8
) (
	input wire clk,
	input wire reset,
	gf_cmd_if.sink chan,
	output logic out_req,
	input wire out_ack,
	output logic [M-1:0] out_result,
	output logic out_div_zero
);
	import gf_field_pkg::*;
	import gf_cmd_pkg::*;

	localparam int CW = $clog2(M);
	localparam logic [CW-1:0] LAST = CW'(M - 2);	// Final squaring cycle
	localparam logic [M_MAX-1:0] ONE_DUAL_FULL = to_dual(M, M_MAX'(1));
	localparam logic [M-1:0] ONE_DUAL = ONE_DUAL_FULL[M-1:0];

	typedef enum logic [2:0] {
		S_IDLE,
		S_DIV,
		S_FINAL,
		S_OUT,
		S_WAIT
	} state_t;

	state_t state;
	logic accept;
	logic is_div;
	logic div_zero;
	logic [M-1:0] num_q;	// Numerator, standard basis
	logic [M-1:0] sq_q;	// Squared denominator, or b for a multiply
	logic [M-1:0] acc_q;	// Dual basis accumulator
	logic [CW-1:0] cycle_cnt;
	logic [M-1:0] mul_std;
	logic [M-1:0] mul_out;
	logic [M_MAX-1:0] dual_a_full;
	logic [M_MAX-1:0] std_res_full;
	gf_result_t res_q;

	// x^2 as a sum of alpha^(2j) columns
	function automatic logic [M-1:0] square(input logic [M-1:0] x);
		logic [M_MAX-1:0] pw;
		logic [M_MAX-1:0] acc;
		pw = M_MAX'(1);
		acc = '0;
		for (int j = 0; j < M; j++) begin
			if (x[j])
				acc ^= pw;
			pw = mul_alpha(M, mul_alpha(M, pw));
		end
		return acc[M-1:0];
	endfunction

	assign accept = (state == S_IDLE) && chan.req && !chan.ack;
	assign dual_a_full = to_dual(M, chan.cmd.a);
	assign mul_std = (state == S_DIV || !is_div) ? sq_q : num_q;	// Numerator on the last step
	assign std_res_full = to_standard(M, M_MAX'(mul_out));

	gf_mixed_multiplier #(
		.M(M)
	) u_mult (
		.dual_in(acc_q),
		.standard_in(mul_std),
		.dual_out(mul_out)
	);

	assign out_req = (state == S_OUT);
	assign out_result = res_q.value[M-1:0];
	assign out_div_zero = res_q.div_zero;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			chan.ack <= 1'b0;
		end else begin
			if (accept)
				chan.ack <= 1'b1;
			else if (chan.ack && !chan.req)
				chan.ack <= 1'b0;	// Source has dropped req
			case (state)
				S_IDLE: if (accept) state <= (chan.cmd.op == OP_DIV) ? S_DIV : S_FINAL;
				S_DIV: if (cycle_cnt == LAST) state <= S_FINAL;
				S_FINAL: state <= S_OUT;
				S_OUT: if (out_ack) state <= S_WAIT;
				S_WAIT: if (!out_ack) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			S_IDLE: begin
				if (accept) begin
					is_div <= (chan.cmd.op == OP_DIV);
					div_zero <= (chan.cmd.op == OP_DIV) && (chan.cmd.b[M-1:0] == '0);
					num_q <= chan.cmd.a[M-1:0];
					cycle_cnt <= '0;
					if (chan.cmd.op == OP_DIV) begin
						sq_q <= square(chan.cmd.b[M-1:0]);	// b^2 is the first factor
						acc_q <= ONE_DUAL;
					end else begin
						sq_q <= chan.cmd.b[M-1:0];
						acc_q <= dual_a_full[M-1:0];
					end
				end
			end
			S_DIV: begin
				acc_q <= mul_out;	// Product of b^(2^k), k = 1..M-1
				sq_q <= square(sq_q);
				cycle_cnt <= cycle_cnt + 1'b1;
			end
			S_FINAL: begin
				res_q.div_zero <= div_zero;
				res_q.value <= div_zero ? '0 : M_MAX'(std_res_full[M-1:0]);
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/gf_arith_top.sv
// GF(2^M) multiply/divide unit with four-phase command and result ports.
// QUEUE_DEPTH must be a power of two; up to QUEUE_DEPTH+2 commands may be in flight.
`timescale 1ns/1ps
`default_nettype none

module gf_arith_top #(
	parameter int M = 8,
	parameter int QUEUE_DEPTH = 4
) (
	input wire clk,
	input wire reset,
	input wire in_req,
	output logic in_ack,
	input wire gf_cmd_pkg::gf_op_t in_op,
	input wire [M-1:0] in_a,
	input wire [M-1:0] in_b,
	output logic out_req,
	input wire out_ack,
	output logic [M-1:0] out_result,
	output logic out_div_zero
);
	import gf_field_pkg::*;
	import gf_cmd_pkg::*;

	gf_cmd_t in_cmd;

	gf_cmd_if intake_to_queue ();
	gf_cmd_if queue_to_engine ();

	// Operands zero-extended to the command width
	assign in_cmd = '{op: in_op, a: M_MAX'(in_a), b: M_MAX'(in_b)};

	gf_op_intake u_intake (
		.clk(clk),
		.reset(reset),
		.in_req(in_req),
		.in_ack(in_ack),
		.in_cmd(in_cmd),
		.chan(intake_to_queue.source)
	);

	gf_cmd_queue #(
		.DEPTH(QUEUE_DEPTH)
	) u_queue (
		.clk(clk),
		.reset(reset),
		.wr(intake_to_queue.sink),
		.rd(queue_to_engine.source)
	);

	gf_arith_engine #(
		.M(M)
	) u_engine (
		.clk(clk),
		.reset(reset),
		.chan(queue_to_engine.sink),
		.out_req(out_req),
		.out_ack(out_ack),
		.out_result(out_result),
		.out_div_zero(out_div_zero)
	);

endmodule

`default_nettype wire

//--- verilog/gf_cmd_if.sv
// Four-phase command channel. The source holds cmd stable while req is high;
// req may rise again only after ack has fallen.
`timescale 1ns/1ps
`default_nettype none

interface gf_cmd_if;
	import gf_cmd_pkg::*;

	logic req;	// Source to sink
	logic ack;	// Sink to source
	gf_cmd_t cmd;

	modport source (
		output req,
		output cmd,
		input ack
	);

	modport sink (
		input req,
		input cmd,
		output ack
	);

endinterface

`default_nettype wire

//--- verilog/gf_cmd_pkg.sv
// Command and result formats of the arithmetic unit.
// Operands are M_MAX wide with the element in the low M bits, upper bits zero.
`default_nettype none

package gf_cmd_pkg;

	typedef enum logic {
		OP_MUL = 1'b0,
		OP_DIV = 1'b1
	} gf_op_t;

	// For a divide, a is the numerator and b the denominator
	typedef struct packed {
		gf_op_t op;
		logic [gf_field_pkg::M_MAX-1:0] a;
		logic [gf_field_pkg::M_MAX-1:0] b;
	} gf_cmd_t;

	typedef struct packed {
		logic div_zero;	// Denominator was zero, value forced to zero
		logic [gf_field_pkg::M_MAX-1:0] value;	// Standard basis
	} gf_result_t;

endpackage

`default_nettype wire

//--- verilog/gf_cmd_queue.sv
// Command FIFO between two four-phase channels. DEPTH must be a power of two, 2 or more.
// A full queue holds off the write-side ack; entries leave in arrival order.
`timescale 1ns/1ps
`default_nettype none

module gf_cmd_queue #(
	parameter int DEPTH = 4
) (
	input wire clk,
	input wire reset,
	gf_cmd_if.sink wr,
	gf_cmd_if.source rd
);
	import gf_cmd_pkg::*;

	localparam int AW = $clog2(DEPTH);

	gf_cmd_t mem [DEPTH];
	logic [AW:0] wr_ptr;	// Extra bit separates full from empty
	logic [AW:0] rd_ptr;
	logic full;
	logic empty;
	logic push;
	logic pop;

	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign push = wr.req && !wr.ack && !full;
	assign pop = rd.req && rd.ack;
	assign rd.cmd = mem[rd_ptr[AW-1:0]];	// Head stays put while rd.req is high

	// Write side handshake
	always_ff @(posedge clk) begin
		if (reset) begin
			wr.ack <= 1'b0;
			wr_ptr <= '0;
		end else if (push) begin
			wr.ack <= 1'b1;
			wr_ptr <= wr_ptr + 1'b1;
		end else if (!wr.req && wr.ack) begin
			wr.ack <= 1'b0;
		end
	end

	// Read side handshake, pop on rising ack
	always_ff @(posedge clk) begin
		if (reset) begin
			rd.req <= 1'b0;
			rd_ptr <= '0;
		end else if (pop) begin
			rd.req <= 1'b0;
			rd_ptr <= rd_ptr + 1'b1;
		end else if (!rd.req && !rd.ack && !empty) begin
			rd.req <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr[AW-1:0]] <= wr.cmd;
	end

endmodule

`default_nettype wire

//--- verilog/gf_field_pkg.sv
// GF(2^M) field support for M from 4 to 10, elements in the low M bits of M_MAX.
// Dual basis is the trace dual of the polynomial basis: d_i = Tr(alpha^i * x).
// Conversion functions are meant for constant folding and small combinational use.
`default_nettype none

package gf_field_pkg;

	localparam int M_MAX = 10;	// Element width carried in commands

	// Low M bits of the primitive polynomial, x^M term implied
	function automatic logic [M_MAX-1:0] poly_for(input int m);
		case (m)
			4: return 10'h003;	// x^4 + x + 1
			5: return 10'h005;	// x^5 + x^2 + 1
			6: return 10'h003;	// x^6 + x + 1
			7: return 10'h003;	// x^7 + x + 1
			8: return 10'h01d;	// x^8 + x^4 + x^3 + x^2 + 1
			9: return 10'h011;	// x^9 + x^4 + 1
			10: return 10'h009;	// x^10 + x^3 + 1
			default: return 10'h003;
		endcase
	endfunction

	// Standard basis element times alpha
	function automatic logic [M_MAX-1:0] mul_alpha(input int m, input logic [M_MAX-1:0] x);
		logic [M_MAX-1:0] mask;
		logic [M_MAX-1:0] y;
		mask = (M_MAX'(1) << m) - 1'b1;
		y = (x << 1) & mask;
		if (x[m-1])
			y ^= poly_for(m);	// Reduce alpha^M
		return y;
	endfunction

	// Tr(alpha^j) for j = 0..m-1, from Newton's identities on the polynomial
	function automatic logic [M_MAX-1:0] trace_vec(input int m);
		logic [M_MAX-1:0] p;
		logic [M_MAX-1:0] s;
		p = poly_for(m);
		s = '0;
		s[0] = m[0];	// Tr(1) = m mod 2
		for (int k = 1; k < m; k++) begin
			s[k] = k[0] & p[m-k];
			for (int i = 1; i < k; i++)
				s[k] ^= p[m-i] & s[k-i];
		end
		return s;
	endfunction

	function automatic logic [M_MAX-1:0] to_dual(input int m, input logic [M_MAX-1:0] x);
		logic [M_MAX-1:0] tr;
		logic [M_MAX-1:0] z;
		logic [M_MAX-1:0] d;
		tr = trace_vec(m);
		z = x;
		d = '0;
		for (int i = 0; i < m; i++) begin
			d[i] = ^(z & tr);	// Tr(alpha^i * x)
			z = mul_alpha(m, z);
		end
		return d;
	endfunction

	// Solves T x = d with T[i][j] = Tr(alpha^(i+j)); T is symmetric and invertible
	function automatic logic [M_MAX-1:0] to_standard(input int m, input logic [M_MAX-1:0] d);
		logic [M_MAX-1:0] rows [M_MAX];
		logic [M_MAX-1:0] rhs;
		logic [M_MAX-1:0] z;
		logic [M_MAX-1:0] swap;
		logic rhs_bit;
		int piv;
		z = M_MAX'(1);
		rhs = d;
		for (int j = 0; j < M_MAX; j++)
			rows[j] = '0;
		for (int j = 0; j < m; j++) begin
			rows[j] = to_dual(m, z);	// Column j equals row j by symmetry
			z = mul_alpha(m, z);
		end
		for (int c = 0; c < m; c++) begin
			piv = c;
			for (int r = m - 1; r >= c; r--)
				if (rows[r][c])
					piv = r;	// Lowest row with a one in column c
			swap = rows[c];
			rows[c] = rows[piv];
			rows[piv] = swap;
			rhs_bit = rhs[c];
			rhs[c] = rhs[piv];
			rhs[piv] = rhs_bit;
			for (int r = 0; r < m; r++) begin
				if (r != c && rows[r][c]) begin
					rows[r] ^= rows[c];
					rhs[r] ^= rhs[c];
				end
			end
		end
		return rhs;
	endfunction

endpackage

`default_nettype wire

//--- verilog/gf_mixed_multiplier.sv
// Bit-parallel Berlekamp multiplier: dual basis times standard basis gives dual basis.
// Purely combinational, one XOR tree per output bit.
`timescale 1ns/1ps
`default_nettype none

module gf_mixed_multiplier #(
	parameter int M = 8
) (
	input wire [M-1:0] dual_in,
	input wire [M-1:0] standard_in,
	output logic [M-1:0] dual_out
);
	import gf_field_pkg::*;

	localparam logic [M_MAX-1:0] POLY_FULL = poly_for(M);
	localparam logic [M-1:0] POLY = POLY_FULL[M-1:0];

	logic [2*M-2:0] terms;	// d_0 .. d_(2M-2) of the dual operand

	always_comb begin
		terms[M-1:0] = dual_in;
		// Tr(alpha^(M+t) x) follows from the polynomial, like an LFSR step
		for (int t = 0; t < M - 1; t++)
			terms[M+t] = ^(terms[t +: M] & POLY);
		for (int k = 0; k < M; k++)
			dual_out[k] = ^(terms[k +: M] & standard_in);
	end

endmodule

`default_nettype wire

//--- verilog/gf_op_intake.sv
// Bridges the external four-phase command port onto the internal channel.
// in_ack rises once the queue has taken the command and falls after in_req is low
// and the channel handshake has closed.
`timescale 1ns/1ps
`default_nettype none

module gf_op_intake (
	input wire clk,
	input wire reset,
	input wire in_req,
	output logic in_ack,
	input wire gf_cmd_pkg::gf_cmd_t in_cmd,
	gf_cmd_if.source chan
);
	import gf_cmd_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_SEND,
		S_DONE
	} state_t;

	state_t state;
	gf_cmd_t cmd_q;

	assign chan.req = (state == S_SEND);
	assign chan.cmd = cmd_q;
	assign in_ack = (state == S_DONE);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: if (in_req) state <= S_SEND;
				S_SEND: if (chan.ack) state <= S_DONE;	// Queue has the entry
				S_DONE: if (!in_req && !chan.ack) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE && in_req)
			cmd_q <= in_cmd;	// Held until the queue acks
	end

endmodule

`default_nettype wire
